//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := queue_table_tb
FILELIST  := queue_table_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "result: FAIL"; exit 1; \
	else \
		echo "result: PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/queue_table_tb.sv
`timescale 1ns/1ps
`include "queue_table_consts.svh"

module queue_table_tb;
    import queue_table_pkg::*;

    localparam int TIMEOUT = 50;

    logic                           pcie_clk;
    logic                           pcie_reset_n;
    logic [`QT_PCIE_ADDR_WIDTH-1:0] pcie_address_0;
    logic                           pcie_write_0;
    logic                           pcie_read_0;
    logic [511:0]                   pcie_writedata_0;
    logic [63:0]                    pcie_byteenable_0;
    logic [511:0]                   pcie_readdata_0;
    logic                           pcie_readdatavalid_0;
    logic                           queue_rd_en;
    queue_idx_t                     rd_queue;
    logic                           tail_wr_en;
    queue_idx_t                     wr_queue;
    rb_ptr_t                        new_dsc_tail;
    rb_ptr_t                        new_pkt_tail;
    logic                           queue_ready;
    rb_ptr_t                        dsc_head;
    rb_ptr_t                        dsc_tail;
    rb_ptr_t                        pkt_head;
    rb_ptr_t                        pkt_tail;
    logic [63:0]                    dsc_buf_addr;
    logic [63:0]                    pkt_buf_addr;
    logic [191:0]                   lookup_state;

    // reference copy of every table with one row per queue
    table_word_t model [`QT_NUM_QUEUES][`QT_NUM_TABLES];

    logic [31:0]  rng_state;
    int           errors;
    int           tests_run;
    int           tests_failed;
    int           err_mark;
    int           cyc = 0;
    string        test_name;
    logic         rd_open;
    logic [511:0] rd_exp;
    logic [191:0] lk_exp;
    logic         lk_d1 = 1'b0;
    logic         lk_d2 = 1'b0;
    logic         lk_d3 = 1'b0;
    logic [191:0] lk_exp_d1;
    logic [191:0] lk_exp_d2;
    logic [191:0] lk_exp_d3;

    queue_table_top queue_table_top_inst (.*);

    assign lookup_state = {dsc_head, dsc_tail, dsc_buf_addr, pkt_head, pkt_tail, pkt_buf_addr};

    initial begin
        pcie_clk = 1'b0;
        forever #4 pcie_clk = ~pcie_clk;
    end

    // lookup requests ride along until their state is due
    always @(posedge pcie_clk) begin
        cyc       <= cyc + 1;
        lk_d1     <= queue_rd_en;
        lk_d2     <= lk_d1;
        lk_d3     <= lk_d2;
        lk_exp_d1 <= lk_exp;
        lk_exp_d2 <= lk_exp_d1;
        lk_exp_d3 <= lk_exp_d2;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_ready_timing : assert property (@(posedge pcie_clk) (cyc > 4) |-> (queue_ready == lk_d3))
        else begin
            errors++;
            $display("Mismatch %s queue_ready: expected %b actual %b",
                     test_name, $sampled(lk_d3), $sampled(queue_ready));
        end

    a_lookup_state : assert property (@(posedge pcie_clk) lk_d3 |-> (lookup_state == lk_exp_d3))
        else begin
            errors++;
            $display("Mismatch %s lookup state: expected %h actual %h",
                     test_name, $sampled(lk_exp_d3), $sampled(lookup_state));
        end

    a_read_data : assert property (@(posedge pcie_clk)
        pcie_readdatavalid_0 |-> (pcie_readdata_0 == rd_exp))
        else begin
            errors++;
            $display("Mismatch %s read data: expected %h actual %h",
                     test_name, $sampled(rd_exp), $sampled(pcie_readdata_0));
        end

    a_no_stray_valid : assert property (@(posedge pcie_clk)
        (cyc > 4 && !rd_open) |-> !pcie_readdatavalid_0)
        else begin
            errors++;
            $display("unexpected read data valid pulse during %s", test_name);
        end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // lcg whose upper bits are the useful ones
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic queue_idx_t rand_queue();
        logic [31:0] r;
        r = next_rand();
        return r[31:28];
    endfunction

    function automatic rb_ptr_t rand_ptr();
        logic [31:0] r;
        r = next_rand();
        return r[31:16];
    endfunction

    function automatic logic [511:0] random_line();
        logic [511:0] v;
        for (int i = 0; i < 16; i++) begin
            v[i*32 +: 32] = next_rand();
        end
        return v;
    endfunction

    // each word gets all bytes on, none or a random mix
    function automatic logic [63:0] random_be();
        logic [63:0] v;
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            case (r[27:26])
                2'd0:    v[i*4 +: 4] = 4'h0;
                2'd1:    v[i*4 +: 4] = r[23:20];
                default: v[i*4 +: 4] = 4'hf;
            endcase
        end
        return v;
    endfunction

    function automatic logic [`QT_PCIE_ADDR_WIDTH-1:0] page_addr(input queue_idx_t q,
                                                               input logic [5:0] line);
        return {q, line, 6'd0};
    endfunction

    function automatic logic [191:0] expected_state(input queue_idx_t q);
        return {model[q][DSC_HEAD][15:0], model[q][DSC_TAIL][15:0],
                model[q][DSC_H_ADDR], model[q][DSC_L_ADDR],
                model[q][PKT_HEAD][15:0], model[q][PKT_TAIL][15:0],
                model[q][PKT_H_ADDR], model[q][PKT_L_ADDR]};
    endfunction

    // upper eight words stay zero
    function automatic logic [511:0] page_words(input queue_idx_t q);
        logic [511:0] v;
        v = '0;
        for (int t = 0; t < `QT_NUM_TABLES; t++) begin
            v[t*32 +: 32] = model[q][t];
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge pcie_clk);
        #1;
        pcie_write_0 = 1'b0;
        pcie_read_0  = 1'b0;
        queue_rd_en  = 1'b0;
        tail_wr_en   = 1'b0;
    endtask

    // host never touches the tails
    task automatic drive_host_write(input queue_idx_t q, input logic [511:0] data,
                                    input logic [63:0] be);
        pcie_address_0    = page_addr(q, 6'd0);
        pcie_write_0      = 1'b1;
        pcie_writedata_0  = data;
        pcie_byteenable_0 = be;
        for (int t = 0; t < `QT_NUM_TABLES; t++) begin
            if (t != int'(DSC_TAIL) && t != int'(PKT_TAIL) && &be[t*4 +: 4]) begin
                model[q][t] = data[t*32 +: 32];
            end
        end
    endtask

    task automatic drive_tail_write(input queue_idx_t q, input rb_ptr_t dsc, input rb_ptr_t pkt);
        tail_wr_en            = 1'b1;
        wr_queue              = q;
        new_dsc_tail          = dsc;
        new_pkt_tail          = pkt;
        model[q][DSC_TAIL]    = {16'd0, dsc};
        model[q][PKT_TAIL]    = {16'd0, pkt};
    endtask

    // call after any same-cycle writes so the model already holds them
    task automatic drive_lookup(input queue_idx_t q);
        queue_rd_en = 1'b1;
        rd_queue    = q;
        lk_exp      = expected_state(q);
    endtask

    task automatic drive_host_read(input queue_idx_t q, input logic [5:0] line);
        pcie_address_0 = page_addr(q, line);
        pcie_read_0    = 1'b1;
        if (line < `QT_REG_LINES) begin
            rd_open = 1'b1;
            rd_exp  = page_words(q);
        end
    endtask

    task automatic wait_read_valid();
        int n;
        n = 0;
        while (!pcie_readdatavalid_0 && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!pcie_readdatavalid_0) begin
            errors++;
            $display("no read data valid pulse within %0d cycles during %s", TIMEOUT, test_name);
        end
        // two more edges so a repeated pulse gets flagged
        next_cycle();
        rd_open = 1'b0;
        next_cycle();
    endtask

    task automatic wait_ready(input int count);
        int seen;
        int n;
        seen = 0;
        n = 0;
        while (seen < count && n < TIMEOUT) begin
            next_cycle();
            n++;
            if (queue_ready) begin
                seen++;
            end
        end
        if (seen < count) begin
            errors++;
            $display("only %0d of %0d lookups became ready during %s", seen, count, test_name);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", test_name, errors - err_mark);
        end else begin
            $display("test %s: pass", test_name);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        queue_idx_t qa;
        queue_idx_t qb;

        rng_state         = 32'd66;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        rd_open           = 1'b0;
        rd_exp            = '0;
        lk_exp            = '0;
        pcie_reset_n      = 1'b0;
        pcie_address_0    = '0;
        pcie_write_0      = 1'b0;
        pcie_read_0       = 1'b0;
        pcie_writedata_0  = '0;
        pcie_byteenable_0 = '0;
        queue_rd_en       = 1'b0;
        rd_queue          = '0;
        tail_wr_en        = 1'b0;
        wr_queue          = '0;
        new_dsc_tail      = '0;
        new_pkt_tail      = '0;

        start_test("reset_idle");
        repeat (16) @(posedge pcie_clk);
        #1;
        pcie_reset_n = 1'b1;
        repeat (4) next_cycle();
        end_test();

        start_test("host_write_read");
        // known contents everywhere first
        for (int q = 0; q < `QT_NUM_QUEUES; q++) begin
            drive_host_write(queue_idx_t'(q), random_line(), '1);
            drive_tail_write(queue_idx_t'(q), rand_ptr(), rand_ptr());
            next_cycle();
        end
        repeat (40) begin
            drive_host_write(rand_queue(), random_line(), random_be());
            next_cycle();
        end
        for (int q = 0; q < `QT_NUM_QUEUES; q++) begin
            drive_host_read(queue_idx_t'(q), 6'd0);
            wait_read_valid();
        end
        drive_host_read(rand_queue(), 6'd3);
        repeat (TIMEOUT) next_cycle();
        end_test();

        start_test("engine_lookup");
        repeat (8) begin
            drive_lookup(rand_queue());
            wait_ready(1);
        end
        qa = rand_queue();
        drive_lookup(qa);
        next_cycle();
        drive_lookup(qa + 4'd1);
        wait_ready(2);
        end_test();

        start_test("tail_write_back");
        qa = rand_queue();
        drive_tail_write(qa, rand_ptr(), rand_ptr());
        next_cycle();
        drive_host_read(qa, 6'd0);
        wait_read_valid();
        drive_lookup(qa);
        wait_ready(1);
        end_test();

        start_test("bypass");
        qb = rand_queue();
        drive_host_write(qb, random_line(), '1);
        drive_lookup(qb);
        wait_ready(1);
        drive_tail_write(qb, rand_ptr(), rand_ptr());
        drive_lookup(qb);
        wait_ready(1);
        drive_lookup(qb);
        wait_ready(1);
        end_test();

        start_test("read_under_writes");
        qa = rand_queue();
        drive_host_read(qa, 6'd0);
        next_cycle();
        repeat (3) begin
            drive_host_write(qa, random_line(), random_be());
            rd_exp = page_words(qa);
            next_cycle();
        end
        wait_read_valid();
        end_test();

        $display("tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- hw/host_access_ctrl.sv
`timescale 1ns/1ps
`include "queue_table_consts.svh"

module host_access_ctrl (
    input  logic                           pcie_clk,
    input  logic                           pcie_reset_n,
    input  logic [`QT_PCIE_ADDR_WIDTH-1:0] pcie_address_0,
    input  logic                           pcie_write_0,
    input  logic                           pcie_read_0,
    input  logic [511:0]                   pcie_writedata_0,
    input  logic [63:0]                    pcie_byteenable_0,
    host_port_if.ctrl                      host [`QT_NUM_TABLES],
    output logic                           read_issued
);
    import queue_table_pkg::*;

    localparam int BYTES_PER_WORD = `QT_WORD_WIDTH / 8;

    queue_idx_t page_idx;
    queue_idx_t rd_queue_pend;
    logic       reg_region;
    logic       reg_read;
    logic       rd_pending;

    // queue comes from the page, region from the line within the page
    assign page_idx   = pcie_address_0[`QT_PAGE_LSB +: `QT_QUEUE_IDX_WIDTH];
    assign reg_region = pcie_address_0[`QT_PAGE_LSB-1:`QT_LINE_LSB] < `QT_REG_LINES;
    assign reg_read   = pcie_read_0 && reg_region;

    ////////////////////////////////////////////////////////////////////////////
    // read staging
    ////////////////////////////////////////////////////////////////////////////

    // writes win the port, so a pended read waits for a write-free cycle
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            rd_pending  <= 1'b0;
            read_issued <= 1'b0;
        end else begin
            read_issued <= rd_pending && !pcie_write_0;
            if (reg_read) begin
                rd_pending <= 1'b1;
            end else if (!pcie_write_0) begin
                rd_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (reg_read) begin
            rd_queue_pend <= page_idx;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // port b requests, one per table
    ////////////////////////////////////////////////////////////////////////////

    for (genvar t = 0; t < `QT_NUM_TABLES; t++) begin : g_tbl
        localparam table_sel_e SEL = table_sel_e'(t);
        // tails belong to the engine
        localparam bit HOST_WR = (SEL != DSC_TAIL) && (SEL != PKT_TAIL);

        logic word_en;

        // all four bytes of the word must be enabled
        assign word_en = &pcie_byteenable_0[t*BYTES_PER_WORD +: BYTES_PER_WORD];

        always_ff @(posedge pcie_clk) begin
            if (!pcie_reset_n) begin
                host[t].op_b <= OP_NONE;
            end else if (pcie_write_0) begin
                host[t].op_b <= (HOST_WR && word_en) ? OP_WRITE : OP_NONE;
            end else if (rd_pending) begin
                host[t].op_b <= OP_READ;
            end else begin
                host[t].op_b <= OP_NONE;
            end
        end

        always_ff @(posedge pcie_clk) begin
            host[t].addr_b    <= pcie_write_0 ? page_idx : rd_queue_pend;
            host[t].wr_data_b <= pcie_writedata_0[t*`QT_WORD_WIDTH +: `QT_WORD_WIDTH];
        end
    end

    // one host read in flight at a time
    a_single_read : assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        rd_pending |-> !reg_read
    ) else $error("host read arrived while another read is pending");

endmodule

//--- hw/queue_state_merge.sv
`timescale 1ns/1ps
`include "queue_table_consts.svh"

module queue_state_merge (
    input  logic                        pcie_clk,
    input  logic                        pcie_reset_n,
    input  logic                        queue_rd_en,
    input  logic                        tail_wr_en,
    input  queue_table_pkg::queue_idx_t rd_queue,
    input  queue_table_pkg::queue_idx_t wr_queue,
    input  queue_table_pkg::rb_ptr_t    new_dsc_tail,
    input  queue_table_pkg::rb_ptr_t    new_pkt_tail,
    engine_port_if.ctrl                 engine [`QT_NUM_TABLES],
    host_port_if.ctrl                   host [`QT_NUM_TABLES],
    input  logic                        read_issued,
    output logic                        queue_ready,
    output queue_table_pkg::rb_ptr_t    dsc_head,
    output queue_table_pkg::rb_ptr_t    dsc_tail,
    output queue_table_pkg::rb_ptr_t    pkt_head,
    output queue_table_pkg::rb_ptr_t    pkt_tail,
    output logic [63:0]                 dsc_buf_addr,
    output logic [63:0]                 pkt_buf_addr,
    output logic [511:0]                pcie_readdata_0,
    output logic                        pcie_readdatavalid_0
);
    import queue_table_pkg::*;

    logic [`QT_NUM_TABLES-1:0] valid_vec;
    table_word_t               eng_word [`QT_NUM_TABLES];
    table_word_t               host_word [`QT_NUM_TABLES];
    logic [1:0]                rd_issued_d;

    for (genvar t = 0; t < `QT_NUM_TABLES; t++) begin : g_eng
        localparam table_sel_e SEL = table_sel_e'(t);
        localparam bit IS_TAIL = (SEL == DSC_TAIL) || (SEL == PKT_TAIL);

        // lookups go everywhere, write-backs only to the tails
        always_ff @(posedge pcie_clk) begin
            if (!pcie_reset_n) begin
                engine[t].op_a[0] <= OP_NONE;
                engine[t].op_a[1] <= OP_NONE;
            end else begin
                engine[t].op_a[0] <= queue_rd_en ? OP_READ : OP_NONE;
                engine[t].op_a[1] <= (IS_TAIL && tail_wr_en) ? OP_WRITE : OP_NONE;
            end
        end

        always_ff @(posedge pcie_clk) begin
            engine[t].addr_a    <= rd_queue;
            engine[t].wr_addr_a <= wr_queue;
            engine[t].wr_data_a <= (SEL == PKT_TAIL) ? table_word_t'(new_pkt_tail)
                                                     : table_word_t'(new_dsc_tail);
        end

        assign valid_vec[t] = engine[t].rd_valid_a;
        assign eng_word[t]  = engine[t].rd_data_a;
        assign host_word[t] = host[t].rd_data_b;
    end

    // every bank sees the same lookup, any of them marks it done
    assign queue_ready  = |valid_vec;
    assign dsc_head     = eng_word[DSC_HEAD][`QT_RB_PTR_WIDTH-1:0];
    assign dsc_tail     = eng_word[DSC_TAIL][`QT_RB_PTR_WIDTH-1:0];
    assign pkt_head     = eng_word[PKT_HEAD][`QT_RB_PTR_WIDTH-1:0];
    assign pkt_tail     = eng_word[PKT_TAIL][`QT_RB_PTR_WIDTH-1:0];
    assign dsc_buf_addr = {eng_word[DSC_H_ADDR], eng_word[DSC_L_ADDR]};
    assign pkt_buf_addr = {eng_word[PKT_H_ADDR], eng_word[PKT_L_ADDR]};

    ////////////////////////////////////////////////////////////////////////////
    // host readback
    ////////////////////////////////////////////////////////////////////////////

    // issue pulse lines up with port b data two cycles on
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            rd_issued_d          <= 2'b00;
            pcie_readdatavalid_0 <= 1'b0;
        end else begin
            rd_issued_d          <= {rd_issued_d[0], read_issued};
            pcie_readdatavalid_0 <= rd_issued_d[1];
        end
    end

    // words 8 to 15 read as zero
    always_ff @(posedge pcie_clk) begin
        if (rd_issued_d[1]) begin
            pcie_readdata_0 <= '0;
            for (int t = 0; t < `QT_NUM_TABLES; t++) begin
                pcie_readdata_0[t*`QT_WORD_WIDTH +: `QT_WORD_WIDTH] <= host_word[t];
            end
        end
    end

endmodule

//--- hw/queue_table_bank.sv
`timescale 1ns/1ps
`include "queue_table_consts.svh"

module queue_table_bank (
    input logic         pcie_clk,
    host_port_if.bank   host,
    engine_port_if.bank engine
);
    import queue_table_pkg::*;

    table_word_t mem [`QT_NUM_QUEUES];

    logic        rd_a;
    logic        wr_a;
    logic        rd_b;
    logic        wr_b;
    logic        hit_a;
    logic        hit_b;
    logic        rd_a_q;
    logic        byp_sel;
    table_word_t byp_word;
    table_word_t mem_q_a;
    table_word_t mem_q_b;

    assign rd_a = engine.op_a[0] == OP_READ;
    assign wr_a = engine.op_a[1] == OP_WRITE;
    assign rd_b = host.op_b == OP_READ;
    assign wr_b = host.op_b == OP_WRITE;

    // lookup meets a write of its own queue in the same cycle
    assign hit_b = rd_a && wr_b && (host.addr_b == engine.addr_a);
    assign hit_a = rd_a && wr_a && (engine.wr_addr_a == engine.addr_a);

    // port a wins if both ports write one entry
    always_ff @(posedge pcie_clk) begin
        if (wr_b) begin
            mem[host.addr_b] <= host.wr_data_b;
        end
        if (wr_a) begin
            mem[engine.wr_addr_a] <= engine.wr_data_a;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // port a, two-stage read with bypass
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge pcie_clk) begin
        // no memory read on a collision
        if (rd_a && !hit_a && !hit_b) begin
            mem_q_a <= mem[engine.addr_a];
        end
        byp_sel  <= hit_a || hit_b;
        byp_word <= hit_a ? engine.wr_data_a : host.wr_data_b;
        rd_a_q   <= rd_a;
    end

    always_ff @(posedge pcie_clk) begin
        engine.rd_data_a  <= byp_sel ? byp_word : mem_q_a;
        engine.rd_valid_a <= rd_a_q;
    end

    ////////////////////////////////////////////////////////////////////////////
    // port b, two-stage read
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge pcie_clk) begin
        if (rd_b) begin
            mem_q_b <= mem[host.addr_b];
        end
        host.rd_data_b <= mem_q_b;
    end

    // a tail write may only ride along with a lookup of the same queue
    a_one_queue_on_a : assert property (
        @(posedge pcie_clk)
        (rd_a && wr_a) |-> (engine.wr_addr_a == engine.addr_a)
    ) else $error("port a write and lookup target different queues");

endmodule

//--- hw/queue_table_consts.svh
`ifndef QUEUE_TABLE_CONSTS_SVH
`define QUEUE_TABLE_CONSTS_SVH

// queue index, carried in the page field of the PCIe address
`define QT_QUEUE_IDX_WIDTH 4
`define QT_NUM_QUEUES 16

// eight tables, one 32-bit word per queue in each
`define QT_NUM_TABLES 8
`define QT_WORD_WIDTH 32

// ring pointers live in the low bits of a table word
`define QT_RB_PTR_WIDTH 16

// PCIe register window layout
`define QT_PCIE_ADDR_WIDTH 16
`define QT_PAGE_LSB 12
`define QT_LINE_LSB 6

// lines at the start of each page that map onto the tables
`define QT_REG_LINES 1

`endif

//--- hw/queue_table_ifs.sv
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// host side of a table (port b)
////////////////////////////////////////////////////////////////////////////

interface host_port_if;
    import queue_table_pkg::*;

    queue_idx_t  addr_b;
    table_word_t wr_data_b;
    port_op_e    op_b;
    table_word_t rd_data_b;

    modport ctrl (
        output addr_b,
        output wr_data_b,
        output op_b,
        input  rd_data_b
    );

    modport bank (
        input  addr_b,
        input  wr_data_b,
        input  op_b,
        output rd_data_b
    );
endinterface

////////////////////////////////////////////////////////////////////////////
// engine side of a table (port a)
////////////////////////////////////////////////////////////////////////////

interface engine_port_if;
    import queue_table_pkg::*;

    // slot 0 carries the lookup, slot 1 the tail write-back
    port_op_e    op_a [2];
    queue_idx_t  addr_a;
    queue_idx_t  wr_addr_a;
    table_word_t wr_data_a;
    table_word_t rd_data_a;
    logic        rd_valid_a;

    modport ctrl (
        output op_a,
        output addr_a,
        output wr_addr_a,
        output wr_data_a,
        input  rd_data_a,
        input  rd_valid_a
    );

    modport bank (
        input  op_a,
        input  addr_a,
        input  wr_addr_a,
        input  wr_data_a,
        output rd_data_a,
        output rd_valid_a
    );
endinterface

//--- hw/queue_table_pkg.sv
`include "queue_table_consts.svh"

package queue_table_pkg;

    // one queue, as taken from the page field
    typedef logic [`QT_QUEUE_IDX_WIDTH-1:0] queue_idx_t;

    // one table entry
    typedef logic [`QT_WORD_WIDTH-1:0] table_word_t;

    // head or tail of a ring buffer
    typedef logic [`QT_RB_PTR_WIDTH-1:0] rb_ptr_t;

    // table order is also the word slot in a 512-bit PCIe line
    typedef enum logic [2:0] {
        DSC_TAIL   = 3'd0,
        DSC_HEAD   = 3'd1,
        DSC_L_ADDR = 3'd2,
        DSC_H_ADDR = 3'd3,
        PKT_TAIL   = 3'd4,
        PKT_HEAD   = 3'd5,
        PKT_L_ADDR = 3'd6,
        PKT_H_ADDR = 3'd7
    } table_sel_e;

    // what a memory port does in a given cycle
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } port_op_e;

endpackage

//--- hw/queue_table_top.sv
`timescale 1ns/1ps
`include "queue_table_consts.svh"

module queue_table_top (
    input  logic                           pcie_clk,
    input  logic                           pcie_reset_n,

    // PCIe register window
    input  logic [`QT_PCIE_ADDR_WIDTH-1:0] pcie_address_0,
    input  logic                           pcie_write_0,
    input  logic                           pcie_read_0,
    input  logic [511:0]                   pcie_writedata_0,
    input  logic [63:0]                    pcie_byteenable_0,
    output logic [511:0]                   pcie_readdata_0,
    output logic                           pcie_readdatavalid_0,

    // fpga2cpu engine
    input  logic                           queue_rd_en,
    input  queue_table_pkg::queue_idx_t    rd_queue,
    input  logic                           tail_wr_en,
    input  queue_table_pkg::queue_idx_t    wr_queue,
    input  queue_table_pkg::rb_ptr_t       new_dsc_tail,
    input  queue_table_pkg::rb_ptr_t       new_pkt_tail,
    output logic                           queue_ready,
    output queue_table_pkg::rb_ptr_t       dsc_head,
    output queue_table_pkg::rb_ptr_t       dsc_tail,
    output logic [63:0]                    dsc_buf_addr,
    output queue_table_pkg::rb_ptr_t       pkt_head,
    output queue_table_pkg::rb_ptr_t       pkt_tail,
    output logic [63:0]                    pkt_buf_addr
);

    logic read_issued;

    host_port_if   host_ports [`QT_NUM_TABLES] ();
    engine_port_if engine_ports [`QT_NUM_TABLES] ();

    host_access_ctrl host_access_ctrl_inst (
        .pcie_clk          (pcie_clk),
        .pcie_reset_n      (pcie_reset_n),
        .pcie_address_0    (pcie_address_0),
        .pcie_write_0      (pcie_write_0),
        .pcie_read_0       (pcie_read_0),
        .pcie_writedata_0  (pcie_writedata_0),
        .pcie_byteenable_0 (pcie_byteenable_0),
        .host              (host_ports),
        .read_issued       (read_issued)
    );

    // one bank per table, in table_sel_e order
    for (genvar t = 0; t < `QT_NUM_TABLES; t++) begin : g_bank
        queue_table_bank queue_table_bank_inst (
            .pcie_clk (pcie_clk),
            .host     (host_ports[t]),
            .engine   (engine_ports[t])
        );
    end

    queue_state_merge queue_state_merge_inst (
        .pcie_clk             (pcie_clk),
        .pcie_reset_n         (pcie_reset_n),
        .queue_rd_en          (queue_rd_en),
        .tail_wr_en           (tail_wr_en),
        .rd_queue             (rd_queue),
        .wr_queue             (wr_queue),
        .new_dsc_tail         (new_dsc_tail),
        .new_pkt_tail         (new_pkt_tail),
        .engine               (engine_ports),
        .host                 (host_ports),
        .read_issued          (read_issued),
        .queue_ready          (queue_ready),
        .dsc_head             (dsc_head),
        .dsc_tail             (dsc_tail),
        .pkt_head             (pkt_head),
        .pkt_tail             (pkt_tail),
        .dsc_buf_addr         (dsc_buf_addr),
        .pkt_buf_addr         (pkt_buf_addr),
        .pcie_readdata_0      (pcie_readdata_0),
        .pcie_readdatavalid_0 (pcie_readdatavalid_0)
    );

endmodule

//--- queue_table_top.f
+incdir+hw
hw/queue_table_pkg.sv
hw/queue_table_ifs.sv
hw/host_access_ctrl.sv
hw/queue_table_bank.sv
hw/queue_state_merge.sv
hw/queue_table_top.sv
bench/queue_table_tb.sv
